//--- Bender.yml
package:
  name: keccak_permutation

sources:
  - files:
      - common/keccak_pkg.sv
      - keccak/keccak_rconst.sv
      - keccak/keccak_round.sv
      - keccak/keccak_permutation.sv
  - target: simulation
    files:
      - sim/keccak_permutation_properties.sv
      - sim/keccak_permutation_tb.sv

//--- common/keccak_pkg.sv
// Keccak package: widths, round count and vector types shared by the permutation core.
package keccak_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sizes fixed by the Keccak-f[1600] algorithm
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // The full sponge state is 25 lanes of 64 bits.
    localparam int STATE_WIDTH = 1600;

    // One lane is the unit that theta, rho and chi operate on.
    localparam int LANE_WIDTH = 64;

    // The state is a 5 x 5 grid of lanes.
    localparam int GRID_SIZE = 5;
    localparam int LANE_COUNT = GRID_SIZE * GRID_SIZE;

    // SHA3-512 absorbs 72 bytes per block, which is the rate.
    localparam int RATE_WIDTH = 576;

    // Keccak-f[1600] always runs 24 rounds per permutation.
    localparam int NUM_ROUNDS = 24;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Vector types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Full state. Lane (x, y) sits at lane index 5*y + x, counted from the
    // most significant end, and each lane is held with its bytes reversed,
    // so message byte 0 lands in the top byte of the vector.
    typedef logic [STATE_WIDTH-1:0] state_t;

    // One absorbed block, aligned to the most significant end of state_t.
    typedef logic [RATE_WIDTH-1:0] rate_block_t;

    // A single lane or a single round constant.
    typedef logic [LANE_WIDTH-1:0] lane_t;

    // One-hot round selector. Bit r set means round r is computed in the
    // current cycle.
    typedef logic [NUM_ROUNDS-1:0] round_sel_t;

endpackage

//--- flist.f
common/keccak_pkg.sv
keccak/keccak_rconst.sv
keccak/keccak_round.sv
keccak/keccak_permutation.sv
sim/keccak_permutation_properties.sv
sim/keccak_permutation_tb.sv

//--- keccak/keccak_permutation.sv
// Keccak-f[1600] permutation: absorbs one rate block and runs 24 rounds, one per clock.
`timescale 1ns/10ps

module keccak_permutation import keccak_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  rate_block_t in,
    input  logic        in_ready,
    output logic        ack,
    output state_t      out,
    output logic        out_ready
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Bit r of the shift register is set while round r is computed, for
    // rounds 1 to 23. Round 0 happens on the accepting edge itself.
    logic [NUM_ROUNDS-1:1] round_shift;

    // High from the accepting edge until the edge that finishes round 23.
    logic busy;

    logic       accept;
    logic       last_round;
    round_sel_t round_sel;
    lane_t      rc;
    state_t     round_in;
    state_t     round_out;

    // A block is taken only while the engine is idle. With the core busy,
    // in_ready may stay high and simply waits for ack.
    assign accept = in_ready & ~busy;
    assign ack    = accept;

    // Bit 0 of the selector is the accept term, so the constant for round
    // 0 is ready in the accepting cycle with no extra latency.
    assign round_sel  = {round_shift, accept};
    assign last_round = round_sel[NUM_ROUNDS-1];

    // The one-hot token walks up by one position per clock and falls off
    // the top after round 23.
    always_ff @(posedge clk) begin
        if (reset) begin
            round_shift <= '0;
        end else begin
            round_shift <= round_sel[NUM_ROUNDS-2:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
        end else begin
            busy <= (busy & ~last_round) | accept;
        end
    end

    // The result flag is set on the edge that completes the last round
    // and stays set until the next block is taken.
    always_ff @(posedge clk) begin
        if (reset) begin
            out_ready <= 1'b0;
        end else if (accept) begin
            out_ready <= 1'b0;
        end else if (last_round) begin
            out_ready <= 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Datapath
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Absorb. The block is XORed into the top of the held state, which
    // chains successive blocks as in the sponge absorb phase. The capacity
    // part below the rate passes through unchanged.
    assign round_in = accept ?
        {out[STATE_WIDTH-1 -: RATE_WIDTH] ^ in, out[STATE_WIDTH-RATE_WIDTH-1:0]} : out;

    keccak_rconst u_rconst (
        .round_sel (round_sel),
        .rc        (rc)
    );

    keccak_round u_round (
        .round_in  (round_in),
        .rc        (rc),
        .round_out (round_out)
    );

    // The state register doubles as the output. It only moves while
    // rounds are being computed, so the result holds between blocks.
    always_ff @(posedge clk) begin
        if (reset) begin
            out <= '0;
        end else if (busy | accept) begin
            out <= round_out;
        end
    end

endmodule

//--- keccak/keccak_rconst.sv
// Keccak round-constant generator: maps the one-hot round selector to the iota constant.
`timescale 1ns/10ps

module keccak_rconst import keccak_pkg::*; (
    input  round_sel_t round_sel,
    output lane_t      rc
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // FIPS 202 round constants in arithmetic lane order
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Entry r is the iota constant of round r, with bit 0 as the least
    // significant bit of the lane value.
    localparam lane_t RC_TABLE [NUM_ROUNDS] = '{
        64'h0000_0000_0000_0001, 64'h0000_0000_0000_8082,
        64'h8000_0000_0000_808a, 64'h8000_0000_8000_8000,
        64'h0000_0000_0000_808b, 64'h0000_0000_8000_0001,
        64'h8000_0000_8000_8081, 64'h8000_0000_0000_8009,
        64'h0000_0000_0000_008a, 64'h0000_0000_0000_0088,
        64'h0000_0000_8000_8009, 64'h0000_0000_8000_000a,
        64'h0000_0000_8000_808b, 64'h8000_0000_0000_008b,
        64'h8000_0000_0000_8089, 64'h8000_0000_0000_8003,
        64'h8000_0000_0000_8002, 64'h8000_0000_0000_0080,
        64'h0000_0000_0000_800a, 64'h8000_0000_8000_000a,
        64'h8000_0000_8000_8081, 64'h8000_0000_0000_8080,
        64'h0000_0000_8000_0001, 64'h8000_0000_8000_8008
    };

    // Selected constant before the byte reversal.
    lane_t rc_value;

    // The selector is one-hot, so masking every table entry with its own
    // select bit and ORing the results is a lookup with no decoder.
    // An all-zero selector gives a zero constant, which leaves the lane
    // untouched.
    always_comb begin
        rc_value = '0;
        for (int r = 0; r < NUM_ROUNDS; r++) begin
            rc_value = rc_value | (RC_TABLE[r] & {LANE_WIDTH{round_sel[r]}});
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Conversion to the stored lane format
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // The state keeps each lane with its bytes reversed, so the constant
    // is handed out in the same order. Byte k of the value moves to the
    // byte slot counted k from the top.
    for (genvar k = 0; k < LANE_WIDTH / 8; k++) begin : g_byte_rev
        assign rc[LANE_WIDTH-8-8*k +: 8] = rc_value[8*k +: 8];
    end

endmodule

//--- keccak/keccak_round.sv
// Keccak round: one complete theta, rho, pi, chi and iota step over the 1600-bit state.
`timescale 1ns/10ps

module keccak_round import keccak_pkg::*; (
    input  state_t round_in,
    input  lane_t  rc,
    output state_t round_out
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Fixed step parameters
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Rho rotation of lane (x, y), listed by lane index 5*y + x.
    localparam int RHO_OFFSET [LANE_COUNT] = '{
         0,  1, 62, 28, 27,
        36, 44,  6, 55, 20,
         3, 10, 43, 25, 39,
        41, 45, 15, 21,  8,
        18,  2, 61, 56, 14
    };

    // Swaps a lane between the stored byte order and arithmetic order.
    // The mapping is its own inverse, so it serves both directions.
    function automatic lane_t swap_bytes(lane_t value);
        lane_t result;
        for (int k = 0; k < LANE_WIDTH / 8; k++) begin
            result[LANE_WIDTH-8-8*k +: 8] = value[8*k +: 8];
        end
        return result;
    endfunction

    // Rotates a lane value towards its most significant bit. A shift by
    // the full lane width yields zero, so a zero offset works too.
    function automatic lane_t rotl(lane_t value, int unsigned amount);
        return (value << amount) | (value >> (LANE_WIDTH - amount));
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Round datapath
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    lane_t a [LANE_COUNT];      // input lanes in arithmetic order
    lane_t c [GRID_SIZE];       // column parities
    lane_t d [GRID_SIZE];       // theta correction per column
    lane_t b [LANE_COUNT];      // lanes after theta, rho and pi
    lane_t e [LANE_COUNT];      // lanes after chi
    lane_t rc_lane;             // round constant in arithmetic order

    always_comb begin
        // Unpack the state. Lane i starts LANE_WIDTH*i bits below the top.
        for (int i = 0; i < LANE_COUNT; i++) begin
            a[i] = swap_bytes(round_in[STATE_WIDTH-1-LANE_WIDTH*i -: LANE_WIDTH]);
        end

        // Theta. Each column parity is the XOR of its five lanes, and every
        // lane then takes the parity of the column to its left and the
        // rotated parity of the column to its right.
        for (int x = 0; x < GRID_SIZE; x++) begin
            c[x] = a[x] ^ a[x+5] ^ a[x+10] ^ a[x+15] ^ a[x+20];
        end
        for (int x = 0; x < GRID_SIZE; x++) begin
            d[x] = c[(x+4)%GRID_SIZE] ^ rotl(c[(x+1)%GRID_SIZE], 1);
        end

        // Rho and pi together. Lane (x, y) is rotated by its fixed offset
        // and moved to position (y, 2x + 3y mod 5).
        for (int y = 0; y < GRID_SIZE; y++) begin
            for (int x = 0; x < GRID_SIZE; x++) begin
                b[GRID_SIZE*((2*x+3*y)%GRID_SIZE) + y] =
                    rotl(a[GRID_SIZE*y+x] ^ d[x], RHO_OFFSET[GRID_SIZE*y+x]);
            end
        end

        // Chi is the only nonlinear step and works along each row.
        for (int y = 0; y < GRID_SIZE; y++) begin
            for (int x = 0; x < GRID_SIZE; x++) begin
                e[GRID_SIZE*y+x] = b[GRID_SIZE*y+x] ^
                    (~b[GRID_SIZE*y+(x+1)%GRID_SIZE] & b[GRID_SIZE*y+(x+2)%GRID_SIZE]);
            end
        end

        // Iota. The constant arrives in stored order and is brought into
        // arithmetic order before it is applied to lane (0, 0).
        rc_lane = swap_bytes(rc);

        // Repack into the stored byte order.
        for (int i = 0; i < LANE_COUNT; i++) begin
            if (i == 0) begin
                round_out[STATE_WIDTH-1-LANE_WIDTH*i -: LANE_WIDTH] =
                    swap_bytes(e[i] ^ rc_lane);
            end else begin
                round_out[STATE_WIDTH-1-LANE_WIDTH*i -: LANE_WIDTH] = swap_bytes(e[i]);
            end
        end
    end

endmodule

//--- sim/keccak_permutation_properties.sv
// Keccak permutation properties: handshake, latency and output hold checks on the top level.
`timescale 1ns/10ps

module keccak_permutation_properties import keccak_pkg::*; (
    input logic   clk,
    input logic   reset,
    input logic   in_ready,
    input logic   ack,
    input state_t out,
    input logic   out_ready
);

    // A block is taken on an edge where both handshake lines are high.
    logic accepted;
    assign accepted = in_ready & ack;

    // Running count of failed assertions.
    int unsigned fail_count = 0;

    // No second block may enter while rounds 1 to 23 are running.
    a_ack_low_while_busy: assert property (@(posedge clk) disable iff (reset)
        accepted |=> !ack [*NUM_ROUNDS-1])
        else begin
            fail_count++;
            $error("ack rose during a permutation");
        end

    a_result_latency: assert property (@(posedge clk) disable iff (reset)
        accepted |-> ##NUM_ROUNDS $rose(out_ready))
        else begin
            fail_count++;
            $error("out_ready did not rise at the expected cycle after accept");
        end

    a_ready_clears: assert property (@(posedge clk) disable iff (reset)
        accepted |=> !out_ready)
        else begin
            fail_count++;
            $error("out_ready stayed high after accept");
        end

    // The result holds until the next block is absorbed.
    a_out_stable: assert property (@(posedge clk) disable iff (reset)
        (out_ready && !ack) |=> $stable(out))
        else begin
            fail_count++;
            $error("out changed while the result was held");
        end

endmodule

bind keccak_permutation keccak_permutation_properties u_properties (
    .clk       (clk),
    .reset     (reset),
    .in_ready  (in_ready),
    .ack       (ack),
    .out       (out),
    .out_ready (out_ready)
);

//--- sim/keccak_permutation_tb.sv
// Keccak permutation testbench: SHA3-512 known answers driven through the absorb handshake.
`timescale 1ns/10ps

module keccak_permutation_tb import keccak_pkg::*; ();

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test table
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int MAX_BLOCKS = 3;
    localparam int BLOCK_BYTES = RATE_WIDTH / 8;
    localparam int MSG_BITS = MAX_BLOCKS * RATE_WIDTH;
    localparam int DIGEST_WIDTH = 512;
    localparam int NUM_TESTS = 5;
    localparam int RESET_CYCLES = 8;
    localparam int GAP_RANGE = 8;
    localparam int RAISE_RANGE = 20;

    // SHA3-512 digests from the FIPS 202 examples, first output byte on the left.
    localparam logic [DIGEST_WIDTH-1:0] EMPTY_DIGEST = {
        256'ha69f73cca23a9ac5c8b567dc185a756e97c982164fe25859e0d1dcc1475c80a6,
        256'h15b2123af1f5f94c11e3e9402c3ac558f500199d95b6d3e301758586281dcd26};
    localparam logic [DIGEST_WIDTH-1:0] ABC_DIGEST = {
        256'hb751850b1a57168a5693cd924b6b096e08f621827444f70d884f5d0240d2712e,
        256'h10e116e9192af3c91a7ec57647e3934057340b4cf408d5a56592f8274eec53f0};
    localparam logic [DIGEST_WIDTH-1:0] A3_DIGEST = {
        256'he76dfad22084a8b1467fcf2ffa58361bec7628edf5f3fdc0e4805dc48caeeca8,
        256'h1b7c13c30adf52a3659584739a2df46be589c51ca1a4a8416df6545a1ce8ba00};

    // One entry per test. The message is padded and left aligned, byte 0 on top.
    typedef struct packed {
        logic [MSG_BITS-1:0]     msg;
        int                      blocks;
        logic                    do_reset;
        logic                    back_pressure;
        logic [DIGEST_WIDTH-1:0] digest;
    } test_entry_t;

    test_entry_t test_table [NUM_TESTS];
    string       test_name [NUM_TESTS];

    logic        clk;
    logic        reset;
    rate_block_t in;
    logic        in_ready;
    logic        ack;
    state_t      out;
    logic        out_ready;

    int          errors = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    logic [31:0] rng;

    keccak_permutation u_dut (
        .clk       (clk),
        .reset     (reset),
        .in        (in),
        .in_ready  (in_ready),
        .ack       (ack),
        .out       (out),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Errors from the testbench checks plus failed assertions in the bound checker.
    function automatic int count_failures();
        return errors + int'(u_dut.u_properties.fail_count);
    endfunction

    // Top bit of state byte j. Byte j lives in lane j/8, and the lane is
    // stored byte-reversed, so byte j%8 of the lane sits j%8 bytes below its top.
    function automatic int byte_top(int j);
        return STATE_WIDTH - 1 - LANE_WIDTH * (j / 8) - 8 * (j % 8);
    endfunction

    function automatic rate_block_t pack_block(logic [MSG_BITS-1:0] msg, int b);
        rate_block_t blk;
        for (int j = 0; j < BLOCK_BYTES; j++) begin
            blk[byte_top(j) - (STATE_WIDTH - RATE_WIDTH) -: 8] =
                msg[MSG_BITS - 1 - 8 * (b * BLOCK_BYTES + j) -: 8];
        end
        return blk;
    endfunction

    function automatic logic [DIGEST_WIDTH-1:0] unpack_digest(state_t s);
        logic [DIGEST_WIDTH-1:0] d;
        for (int j = 0; j < DIGEST_WIDTH / 8; j++) begin
            d[DIGEST_WIDTH - 1 - 8 * j -: 8] = s[byte_top(j) -: 8];
        end
        return d;
    endfunction

    task automatic set_entry(input int idx, input string name, input logic [MSG_BITS-1:0] msg,
                             input int blocks, input logic bp,
                             input logic [DIGEST_WIDTH-1:0] digest);
        test_name[idx] = name;
        test_table[idx].msg = msg;
        test_table[idx].blocks = blocks;
        test_table[idx].do_reset = 1'b1;
        test_table[idx].back_pressure = bp;
        test_table[idx].digest = digest;
    endtask

    // Messages carry the SHA3 suffix 0x06 and the final 0x80 of the last block.
    task automatic fill_table();
        logic [MSG_BITS-1:0] empty_msg;
        logic [MSG_BITS-1:0] a3_msg;
        empty_msg = {8'h06, {70{8'h00}}, 8'h80, {(MSG_BITS - RATE_WIDTH){1'b0}}};
        a3_msg = {{200{8'ha3}}, 8'h06, {14{8'h00}}, 8'h80};
        set_entry(0, "empty message", empty_msg, 1, 1'b0, EMPTY_DIGEST);
        set_entry(1, "abc", {8'h61, 8'h62, 8'h63, 8'h06, {67{8'h00}}, 8'h80,
                  {(MSG_BITS - RATE_WIDTH){1'b0}}}, 1, 1'b0, ABC_DIGEST);
        set_entry(2, "200 x a3 with idle gaps", a3_msg, 3, 1'b0, A3_DIGEST);
        set_entry(3, "200 x a3 with back-pressure", a3_msg, 3, 1'b1, A3_DIGEST);
        set_entry(4, "empty message after reset", empty_msg, 1, 1'b0, EMPTY_DIGEST);
    endtask

    // Leaves the caller on a falling edge with reset just released.
    task automatic apply_reset();
        @(negedge clk);
        reset = 1'b1;
        in_ready = 1'b0;
        in = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        if (out_ready !== 1'b0 || out !== '0 || ack !== in_ready) begin
            $display("Mismatch at %0t: after reset out_ready=%b ack=%b out nonzero=%b",
                     $time, out_ready, ack, |out);
            errors++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Entry runner
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic run_entry(input int t);
        int gap;
        int raise_at;
        int cycles;
        logic [DIGEST_WIDTH-1:0] got;
        if (test_table[t].do_reset) apply_reset();
        for (int b = 0; b < test_table[t].blocks; b++) begin
            // Under back-pressure the block is already waiting on in.
            if (!in_ready) begin
                rng = xorshift32(rng);
                gap = rng % GAP_RANGE;
                repeat (gap) @(negedge clk);
                in = pack_block(test_table[t].msg, b);
                in_ready = 1'b1;
            end
            #1;
            if (!ack) begin
                $display("Block %0d of test %0d was not taken by an idle core", b, t);
                errors++;
            end
            while (!ack) begin
                @(negedge clk);
                #1;
            end
            @(posedge clk);
            @(negedge clk);
            in_ready = 1'b0;
            if (out_ready !== 1'b0) begin
                $display("Mismatch at %0t: out_ready still high after accept", $time);
                errors++;
            end
            // Count falling edges until the result flag rises.
            rng = xorshift32(rng);
            raise_at = 1 + rng % RAISE_RANGE;
            cycles = 1;
            while (!out_ready) begin
                if (test_table[t].back_pressure && b + 1 < test_table[t].blocks &&
                    cycles == raise_at) begin
                    in = pack_block(test_table[t].msg, b + 1);
                    in_ready = 1'b1;
                end
                #1;
                if (ack) begin
                    $display("The core raised ack at %0t while still busy", $time);
                    errors++;
                end
                @(negedge clk);
                cycles++;
            end
            if (cycles != NUM_ROUNDS) begin
                $display("Mismatch at %0t: latency %0d cycles, expected %0d",
                         $time, cycles, NUM_ROUNDS);
                errors++;
            end
        end
        got = unpack_digest(out);
        if (got !== test_table[t].digest) begin
            $display("Mismatch at %0t: digest %h, expected %h", $time, got,
                     test_table[t].digest);
            errors++;
        end
    endtask

    // The limit scales with the number of blocks in the table.
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        int total_blocks;
        int start_errors;
        int passed;
        int failures;
        reset = 1'b1;
        in = '0;
        in_ready = 1'b0;
        rng = 32'h338a_201e;
        total_blocks = 0;
        passed = 0;
        fill_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            total_blocks += test_table[t].blocks;
        end
        cycle_limit = total_blocks * 40 + 200;
        for (int t = 0; t < NUM_TESTS; t++) begin
            start_errors = count_failures();
            run_entry(t);
            if (count_failures() == start_errors) begin
                passed++;
                $display("Test %0d (%s): passed", t, test_name[t]);
            end else begin
                $display("Test %0d (%s): %0d errors", t, test_name[t],
                         count_failures() - start_errors);
            end
        end
        failures = count_failures();
        $display("Summary: %0d of %0d tests passed, %0d errors", passed, NUM_TESTS, failures);
        if (failures == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
